// File: src/mem_ctrl_defines.svh
// Sizes of the controller; the consumer count must be at least 2 and the channel count at most it
`ifndef MEM_CTRL_DEFINES_SVH
`define MEM_CTRL_DEFINES_SVH

// Width of one memory address in bits
// The external memory holds 2**MC_ADDR_BITS words
`define MC_ADDR_BITS 8

// Width of one data word in bits
// Reads and writes always move a whole word since there are no byte enables
`define MC_DATA_BITS 16

// Number of consumer ports such as fetchers and load/store units
// Each consumer has at most one request outstanding
`define MC_NUM_CONSUMERS 4

// Number of memory channels that run transactions side by side
// This bounds how many requests are in flight toward memory at once
`define MC_NUM_CHANNELS 2

`endif

// File: src/mem_ctrl_pkg.sv
// Shared types of the controller; field widths follow the macros of the defines header
`default_nettype none

`include "mem_ctrl_defines.svh"

package mem_ctrl_pkg;

    // Index of one consumer port
    localparam int CONSUMER_IDX_BITS = $clog2(`MC_NUM_CONSUMERS);
    typedef logic [CONSUMER_IDX_BITS-1:0] consumer_idx_t;

    // Request from one consumer with exactly one valid raised at a time
    typedef struct packed {
        logic                     read_valid;
        logic                     write_valid;
        logic [`MC_ADDR_BITS-1:0] address;
        logic [`MC_DATA_BITS-1:0] write_data;
    } consumer_req_t;

    // Response toward one consumer
    typedef struct packed {
        logic                     read_ready;
        logic                     write_ready;
        logic [`MC_DATA_BITS-1:0] read_data;
    } consumer_rsp_t;

    // Request of one channel toward external memory
    typedef struct packed {
        logic                     read_valid;
        logic                     write_valid;
        logic [`MC_ADDR_BITS-1:0] address;
        logic [`MC_DATA_BITS-1:0] write_data;
    } channel_req_t;

    // Answer of external memory on one channel
    typedef struct packed {
        logic                     read_ready;
        logic                     write_ready;
        logic [`MC_DATA_BITS-1:0] read_data;
    } channel_rsp_t;

    // Life cycle of one channel
    typedef enum logic [2:0] {
        IDLE,
        READ_WAITING,
        WRITE_WAITING,
        READ_RELAYING,
        WRITE_RELAYING
    } channel_state_e;

    // Per-channel command from the scheduler to the datapath
    // Launch, retire and release_consumer are single-cycle pulses
    typedef struct packed {
        logic          launch;
        logic          retire;
        logic          release_consumer;
        logic          is_write;
        consumer_idx_t consumer;
    } channel_cmd_t;

endpackage

`default_nettype wire

// File: src/channel_scheduler.sv
// Control of all channels; assumes consumers hold valid until ready and memory holds ready while valid
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module channel_scheduler
    import mem_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  consumer_req_t consumer_req [`MC_NUM_CONSUMERS],
    input  channel_rsp_t  channel_rsp  [`MC_NUM_CHANNELS],
    output channel_cmd_t  channel_cmd  [`MC_NUM_CHANNELS]
);

    // State of each channel and the consumer it serves
    channel_state_e state_q    [`MC_NUM_CHANNELS];
    channel_state_e state_d    [`MC_NUM_CHANNELS];
    consumer_idx_t  consumer_q [`MC_NUM_CHANNELS];
    consumer_idx_t  consumer_d [`MC_NUM_CHANNELS];

    // One bit per consumer that some channel is holding
    logic [`MC_NUM_CONSUMERS-1:0] busy_q;
    logic [`MC_NUM_CONSUMERS-1:0] busy_d;

    // Commands for the next cycle
    channel_cmd_t cmd_d [`MC_NUM_CHANNELS];

    always_comb begin
        logic [`MC_NUM_CONSUMERS-1:0] claimed;
        logic [`MC_NUM_CONSUMERS-1:0] freed;
        logic                         found;
        logic                         take_read;
        claimed = '0;
        freed   = '0;
        // Channels are visited in index order so channel 0 picks first
        for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
            state_d[ch]        = state_q[ch];
            consumer_d[ch]     = consumer_q[ch];
            cmd_d[ch]          = '0;
            cmd_d[ch].consumer = consumer_q[ch];
            // Retire and release carry the direction of the running transaction
            cmd_d[ch].is_write = (state_q[ch] == WRITE_WAITING) ||
                                 (state_q[ch] == WRITE_RELAYING);
            found     = 1'b0;
            take_read = 1'b0;
            case (state_q[ch])
                IDLE: begin
                    // Lowest free consumer with any valid wins
                    // A consumer claimed by an earlier channel this cycle is skipped
                    for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
                        if (!found && !busy_q[c] && !claimed[c] &&
                            (consumer_req[c].read_valid || consumer_req[c].write_valid)) begin
                            found          = 1'b1;
                            take_read      = consumer_req[c].read_valid;
                            claimed[c]     = 1'b1;
                            consumer_d[ch] = consumer_idx_t'(c);
                        end
                    end
                    if (found) begin
                        cmd_d[ch].launch   = 1'b1;
                        // Read is preferred when a consumer holds both valids
                        cmd_d[ch].is_write = !take_read;
                        cmd_d[ch].consumer = consumer_d[ch];
                        state_d[ch]        = take_read ? READ_WAITING : WRITE_WAITING;
                    end
                end
                READ_WAITING: begin
                    if (channel_rsp[ch].read_ready) begin
                        cmd_d[ch].retire = 1'b1;
                        state_d[ch]      = READ_RELAYING;
                    end
                end
                WRITE_WAITING: begin
                    if (channel_rsp[ch].write_ready) begin
                        cmd_d[ch].retire = 1'b1;
                        state_d[ch]      = WRITE_RELAYING;
                    end
                end
                // Wait for the consumer to drop its valid after it saw ready
                READ_RELAYING: begin
                    if (!consumer_req[consumer_q[ch]].read_valid) begin
                        cmd_d[ch].release_consumer = 1'b1;
                        freed[consumer_q[ch]]      = 1'b1;
                        state_d[ch]                = IDLE;
                    end
                end
                WRITE_RELAYING: begin
                    if (!consumer_req[consumer_q[ch]].write_valid) begin
                        cmd_d[ch].release_consumer = 1'b1;
                        freed[consumer_q[ch]]      = 1'b1;
                        state_d[ch]                = IDLE;
                    end
                end
                default: begin
                    state_d[ch] = IDLE;
                end
            endcase
        end
        // A freed consumer is only visible to the choice in the next cycle
        busy_d = (busy_q & ~freed) | claimed;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= '0;
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                state_q[ch]     <= IDLE;
                consumer_q[ch]  <= '0;
                channel_cmd[ch] <= '0;
            end
        end else begin
            busy_q      <= busy_d;
            state_q     <= state_d;
            consumer_q  <= consumer_d;
            channel_cmd <= cmd_d;
        end
    end

endmodule

`default_nettype wire

// File: src/request_launcher.sv
// Outgoing channel requests; address and data are only meaningful while a channel valid is high
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module request_launcher
    import mem_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  consumer_req_t consumer_req [`MC_NUM_CONSUMERS],
    input  channel_cmd_t  channel_cmd  [`MC_NUM_CHANNELS],
    output channel_req_t  channel_req  [`MC_NUM_CHANNELS]
);

    // Valids toward memory
    logic [`MC_NUM_CHANNELS-1:0] read_valid_q;
    logic [`MC_NUM_CHANNELS-1:0] write_valid_q;

    // Request payload copied from the chosen consumer
    logic [`MC_ADDR_BITS-1:0] address_q    [`MC_NUM_CHANNELS];
    logic [`MC_DATA_BITS-1:0] write_data_q [`MC_NUM_CHANNELS];

    // Valids rise on launch and fall on retire
    always_ff @(posedge clk) begin
        if (reset) begin
            read_valid_q  <= '0;
            write_valid_q <= '0;
        end else begin
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                if (channel_cmd[ch].launch) begin
                    read_valid_q[ch]  <= !channel_cmd[ch].is_write;
                    write_valid_q[ch] <= channel_cmd[ch].is_write;
                end else if (channel_cmd[ch].retire) begin
                    read_valid_q[ch]  <= 1'b0;
                    write_valid_q[ch] <= 1'b0;
                end
            end
        end
    end

    // The consumer keeps its request stable while valid so the copy is taken at launch
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
            if (channel_cmd[ch].launch) begin
                address_q[ch]    <= consumer_req[channel_cmd[ch].consumer].address;
                write_data_q[ch] <= consumer_req[channel_cmd[ch].consumer].write_data;
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
            channel_req[ch].read_valid  = read_valid_q[ch];
            channel_req[ch].write_valid = write_valid_q[ch];
            channel_req[ch].address     = address_q[ch];
            channel_req[ch].write_data  = write_data_q[ch];
        end
    end

endmodule

`default_nettype wire

// File: src/response_router.sv
// Responses to consumers; read data holds its last value until the next read of that consumer
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module response_router
    import mem_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  channel_cmd_t  channel_cmd  [`MC_NUM_CHANNELS],
    input  channel_rsp_t  channel_rsp  [`MC_NUM_CHANNELS],
    output consumer_rsp_t consumer_rsp [`MC_NUM_CONSUMERS]
);

    // Ready flags per consumer
    logic [`MC_NUM_CONSUMERS-1:0] read_ready_q;
    logic [`MC_NUM_CONSUMERS-1:0] write_ready_q;

    // Last read word returned to each consumer
    logic [`MC_DATA_BITS-1:0] read_data_q [`MC_NUM_CONSUMERS];

    always_ff @(posedge clk) begin
        if (reset) begin
            read_ready_q  <= '0;
            write_ready_q <= '0;
            for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
                read_data_q[c] <= '0;
            end
        end else begin
            // No two channels name the same consumer in one cycle
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                if (channel_cmd[ch].retire) begin
                    if (channel_cmd[ch].is_write) begin
                        write_ready_q[channel_cmd[ch].consumer] <= 1'b1;
                    end else begin
                        read_ready_q[channel_cmd[ch].consumer] <= 1'b1;
                        // Memory still drives the word since the channel valid drops only now
                        read_data_q[channel_cmd[ch].consumer]  <= channel_rsp[ch].read_data;
                    end
                end
                // Consumer has dropped valid so the ready goes away
                if (channel_cmd[ch].release_consumer) begin
                    if (channel_cmd[ch].is_write) begin
                        write_ready_q[channel_cmd[ch].consumer] <= 1'b0;
                    end else begin
                        read_ready_q[channel_cmd[ch].consumer] <= 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            consumer_rsp[c].read_ready  = read_ready_q[c];
            consumer_rsp[c].write_ready = write_ready_q[c];
            consumer_rsp[c].read_data   = read_data_q[c];
        end
    end

endmodule

`default_nettype wire

// File: src/mem_ctrl_top.sv
// Global memory controller; external memory must keep ready high for as long as valid is high
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module mem_ctrl_top
    import mem_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    // Consumer side
    input  consumer_req_t consumer_req [`MC_NUM_CONSUMERS],
    output consumer_rsp_t consumer_rsp [`MC_NUM_CONSUMERS],
    // Memory side
    output channel_req_t  channel_req  [`MC_NUM_CHANNELS],
    input  channel_rsp_t  channel_rsp  [`MC_NUM_CHANNELS]
);

    // Commands shared by both datapath blocks
    channel_cmd_t channel_cmd [`MC_NUM_CHANNELS];

    // Decides every handshake condition and emits pulses
    channel_scheduler i_scheduler (
        .clk          (clk),
        .reset        (reset),
        .consumer_req (consumer_req),
        .channel_rsp  (channel_rsp),
        .channel_cmd  (channel_cmd)
    );

    // Consumer to channel multiplexer
    request_launcher i_launcher (
        .clk          (clk),
        .reset        (reset),
        .consumer_req (consumer_req),
        .channel_cmd  (channel_cmd),
        .channel_req  (channel_req)
    );

    // Channel to consumer demultiplexer
    response_router i_router (
        .clk          (clk),
        .reset        (reset),
        .channel_cmd  (channel_cmd),
        .channel_rsp  (channel_rsp),
        .consumer_rsp (consumer_rsp)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
// Behavioral external memory; a channel answers after LATENCY cycles of valid and stall freezes every channel
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module tb_mem_model
    import mem_ctrl_pkg::*;
#(
    parameter int LATENCY = 3
) (
    input  logic         clk,
    input  logic         reset,
    // Holds every ready low while high
    input  logic         stall,
    input  channel_req_t channel_req [`MC_NUM_CHANNELS],
    output channel_rsp_t channel_rsp [`MC_NUM_CHANNELS]
);

    // Backing store, read by the testbench to confirm writes
    logic [`MC_DATA_BITS-1:0] mem [2**`MC_ADDR_BITS];

    // Cycles each channel has waited so far
    int wait_count [`MC_NUM_CHANNELS];

    // Preload pattern built from every bit of the address
    initial begin
        logic [`MC_ADDR_BITS-1:0] addr;
        for (int a = 0; a < 2**`MC_ADDR_BITS; a++) begin
            addr   = a[`MC_ADDR_BITS-1:0];
            mem[a] = {addr ^ 8'h3c, ~addr};
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                channel_rsp[ch] <= '0;
                wait_count[ch]  <= 0;
            end
        end else begin
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                if (!channel_req[ch].read_valid && !channel_req[ch].write_valid) begin
                    channel_rsp[ch].read_ready  <= 1'b0;
                    channel_rsp[ch].write_ready <= 1'b0;
                    wait_count[ch]              <= 0;
                end else if (!stall && !channel_rsp[ch].read_ready &&
                             !channel_rsp[ch].write_ready) begin
                    // Once raised, ready stays up until the channel drops valid
                    if (wait_count[ch] + 1 < LATENCY) begin
                        wait_count[ch] <= wait_count[ch] + 1;
                    end else if (channel_req[ch].write_valid) begin
                        mem[channel_req[ch].address] <= channel_req[ch].write_data;
                        channel_rsp[ch].write_ready  <= 1'b1;
                    end else begin
                        channel_rsp[ch].read_data  <= mem[channel_req[ch].address];
                        channel_rsp[ch].read_ready <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/mem_ctrl_assert.sv
// Protocol checks bound onto the controller top; the serving record follows the scheduler commands
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module mem_ctrl_assert
    import mem_ctrl_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input consumer_req_t consumer_req [`MC_NUM_CONSUMERS],
    input consumer_rsp_t consumer_rsp [`MC_NUM_CONSUMERS],
    input channel_req_t  channel_req  [`MC_NUM_CHANNELS],
    input channel_cmd_t  channel_cmd  [`MC_NUM_CHANNELS]
);

    // Number of assertion failures so far
    int assert_failures = 0;

    // Consumer that each channel holds between launch and release
    logic [`MC_NUM_CHANNELS-1:0] serving;
    consumer_idx_t               served [`MC_NUM_CHANNELS];

    always @(posedge clk) begin
        if (reset) begin
            serving <= '0;
        end else begin
            for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                if (channel_cmd[ch].launch) begin
                    serving[ch] <= 1'b1;
                    served[ch]  <= channel_cmd[ch].consumer;
                end else if (channel_cmd[ch].release_consumer) begin
                    serving[ch] <= 1'b0;
                end
            end
        end
    end

    for (genvar ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin : g_channel
        // A channel carries one direction and only one that its consumer still requests
        assert property (@(posedge clk) disable iff (reset)
            !(channel_req[ch].read_valid && channel_req[ch].write_valid) &&
            (!channel_req[ch].read_valid || consumer_req[served[ch]].read_valid) &&
            (!channel_req[ch].write_valid || consumer_req[served[ch]].write_valid))
        else begin
            assert_failures++;
            $error("channel %0d drives both valids or one its consumer does not hold", ch);
        end
        assert property (@(posedge clk)
            $fell(reset) |-> !channel_req[ch].read_valid && !channel_req[ch].write_valid)
        else begin
            assert_failures++;
            $error("channel %0d valid high right after reset", ch);
        end
        for (genvar other = ch + 1; other < `MC_NUM_CHANNELS; other++) begin : g_pair
            assert property (@(posedge clk) disable iff (reset)
                !(serving[ch] && serving[other] && served[ch] == served[other]))
            else begin
                assert_failures++;
                $error("channels %0d and %0d serve one consumer", ch, other);
            end
        end
    end

    // The consumer drops valid one cycle after it sees ready so the check looks one cycle back
    for (genvar c = 0; c < `MC_NUM_CONSUMERS; c++) begin : g_consumer
        assert property (@(posedge clk) disable iff (reset)
            $rose(consumer_rsp[c].read_ready) |-> $past(consumer_req[c].read_valid))
        else begin
            assert_failures++;
            $error("read ready of consumer %0d rose without a read", c);
        end
        assert property (@(posedge clk) disable iff (reset)
            $rose(consumer_rsp[c].write_ready) |-> $past(consumer_req[c].write_valid))
        else begin
            assert_failures++;
            $error("write ready of consumer %0d rose without a write", c);
        end
    end

endmodule

bind mem_ctrl_top mem_ctrl_assert i_assert (
    .clk          (clk),
    .reset        (reset),
    .consumer_req (consumer_req),
    .consumer_rsp (consumer_rsp),
    .channel_req  (channel_req),
    .channel_cmd  (channel_cmd)
);

`default_nettype wire

// File: testbench/tb_mem_ctrl.sv
// Directed testbench of the controller; consumers follow the level handshake and memory latency is fixed
`default_nettype none
`timescale 1ns/100ps

`include "mem_ctrl_defines.svh"

module tb_mem_ctrl
    import mem_ctrl_pkg::*;
();

    localparam int MEM_LATENCY  = 3;
    localparam int STALL_CYCLES = 20;
    // One transaction is roughly launch, memory latency, relay and release
    localparam int TXN_CYCLES      = MEM_LATENCY + 8;
    // Twenty-two transactions over all tests plus the stall window
    localparam int TEST_CYCLES     = 22 * TXN_CYCLES + STALL_CYCLES + 10;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

    typedef logic [`MC_ADDR_BITS-1:0] addr_t;
    typedef logic [`MC_DATA_BITS-1:0] data_t;

    logic          clk;
    logic          reset;
    logic          stall;
    consumer_req_t consumer_req [`MC_NUM_CONSUMERS];
    consumer_rsp_t consumer_rsp [`MC_NUM_CONSUMERS];
    channel_req_t  channel_req  [`MC_NUM_CHANNELS];
    channel_rsp_t  channel_rsp  [`MC_NUM_CHANNELS];

    // Expected memory contents
    data_t shadow [2**`MC_ADDR_BITS];
    int    seed   = 32'h3b9b;
    int    checks = 0;
    int    errors = 0;

    mem_ctrl_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .consumer_req (consumer_req),
        .consumer_rsp (consumer_rsp),
        .channel_req  (channel_req),
        .channel_rsp  (channel_rsp)
    );

    tb_mem_model #(.LATENCY(MEM_LATENCY)) i_mem (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .channel_req (channel_req),
        .channel_rsp (channel_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Preload rule of the memory model
    function automatic data_t fill_word(input addr_t a);
        return {a ^ 8'h3c, ~a};
    endfunction

    function automatic addr_t random_addr();
        int r;
        r = $random(seed);
        return r[`MC_ADDR_BITS-1:0];
    endfunction

    function automatic data_t random_data();
        int r;
        r = $random(seed);
        return r[`MC_DATA_BITS-1:0];
    endfunction

    // Response a consumer should see when its read of a completes
    function automatic consumer_rsp_t expected_read(input addr_t a);
        return '{read_ready: 1'b1, write_ready: 1'b0, read_data: shadow[a]};
    endfunction

    task automatic compare_read_data(input string what, input consumer_rsp_t got,
                                     input consumer_rsp_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s returned %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic compare_ack(input string what, input bit got, input bit expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0b, expected %0b", $time, what, got, expected);
        end
    endtask

    // One read with the full level handshake
    task automatic issue_read(input int c, input addr_t addr, output consumer_rsp_t rsp);
        @(posedge clk);
        #1;
        consumer_req[c].address    = addr;
        consumer_req[c].read_valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!consumer_rsp[c].read_ready);
        rsp = consumer_rsp[c];
        consumer_req[c].read_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (consumer_rsp[c].read_ready);
    endtask

    task automatic issue_write(input int c, input addr_t addr, input data_t data);
        @(posedge clk);
        #1;
        consumer_req[c].address     = addr;
        consumer_req[c].write_data  = data;
        consumer_req[c].write_valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!consumer_rsp[c].write_ready);
        compare_ack($sformatf("read ready of consumer %0d on write ack", c),
                    consumer_rsp[c].read_ready, 1'b0);
        consumer_req[c].write_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (consumer_rsp[c].write_ready);
    endtask

    task automatic verify_reset_state();
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            compare_read_data($sformatf("consumer %0d after reset", c), consumer_rsp[c], '0);
        end
        for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
            compare_ack("channel valid after reset",
                        channel_req[ch].read_valid | channel_req[ch].write_valid, 1'b0);
        end
    endtask

    task automatic read_each_consumer();
        addr_t         a;
        consumer_rsp_t got;
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            a = random_addr();
            issue_read(c, a, got);
            compare_read_data($sformatf("single read by consumer %0d", c), got, expected_read(a));
        end
    endtask

    task automatic write_then_read_back();
        addr_t         a;
        data_t         d;
        consumer_rsp_t got;
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            a = random_addr();
            d = random_data();
            issue_write(c, a, d);
            shadow[a] = d;
            compare_ack("memory holds written word", i_mem.mem[a] === d, 1'b1);
            issue_read(c, a, got);
            compare_read_data($sformatf("read back by consumer %0d", c), got, expected_read(a));
        end
    endtask

    task automatic load_all_consumers();
        addr_t         a    [`MC_NUM_CONSUMERS];
        consumer_rsp_t got  [`MC_NUM_CONSUMERS];
        int            rise [`MC_NUM_CONSUMERS];
        int            cycle;
        int            high;
        int            peak;
        bit            all_done;
        cycle    = 0;
        peak     = 0;
        all_done = 1'b0;
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            a[c]    = random_addr();
            rise[c] = -1;
        end
        fork
            begin
                fork
                    issue_read(0, a[0], got[0]);
                    issue_read(1, a[1], got[1]);
                    issue_read(2, a[2], got[2]);
                    issue_read(3, a[3], got[3]);
                join
                all_done = 1'b1;
            end
            // Track the most channel valids seen together and the cycle each ready first shows
            begin
                while (!all_done) begin
                    @(posedge clk);
                    #1;
                    cycle++;
                    high = 0;
                    for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                        if (channel_req[ch].read_valid || channel_req[ch].write_valid) begin
                            high++;
                        end
                    end
                    if (high > peak) begin
                        peak = high;
                    end
                    for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
                        if (rise[c] < 0 && consumer_rsp[c].read_ready) begin
                            rise[c] = cycle;
                        end
                    end
                end
            end
        join
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            compare_read_data($sformatf("loaded read by consumer %0d", c), got[c],
                              expected_read(a[c]));
        end
        compare_ack("both channels in flight together", peak == `MC_NUM_CHANNELS, 1'b1);
        compare_ack("consumer 0 served no later than consumer 2", rise[0] <= rise[2], 1'b1);
    endtask

    task automatic hold_back_pressure();
        addr_t         a   [`MC_NUM_CONSUMERS];
        data_t         d   [2];
        consumer_rsp_t got [2];
        addr_t         base;
        base = random_addr();
        // Spread addresses so reads and writes never meet
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            a[c] = base + addr_t'(c * 37);
        end
        d[0] = random_data();
        d[1] = random_data();
        @(posedge clk);
        #1;
        stall = 1'b1;
        fork
            issue_read(0, a[0], got[0]);
            issue_read(1, a[1], got[1]);
            issue_write(2, a[2], d[0]);
            issue_write(3, a[3], d[1]);
            begin
                repeat (STALL_CYCLES) begin
                    @(posedge clk);
                    #1;
                    for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
                        compare_ack("consumer ready under stall",
                                    consumer_rsp[c].read_ready | consumer_rsp[c].write_ready, 1'b0);
                    end
                end
                for (int ch = 0; ch < `MC_NUM_CHANNELS; ch++) begin
                    compare_ack("channel valid under stall",
                                channel_req[ch].read_valid | channel_req[ch].write_valid, 1'b1);
                end
                stall = 1'b0;
            end
        join
        compare_read_data("stalled read by consumer 0", got[0], expected_read(a[0]));
        compare_read_data("stalled read by consumer 1", got[1], expected_read(a[1]));
        shadow[a[2]] = d[0];
        shadow[a[3]] = d[1];
        compare_ack("memory holds stalled write 2", i_mem.mem[a[2]] === d[0], 1'b1);
        compare_ack("memory holds stalled write 3", i_mem.mem[a[3]] === d[1], 1'b1);
    endtask

    task automatic prefer_read_over_write();
        addr_t a;
        data_t d;
        a = random_addr();
        d = random_data();
        @(posedge clk);
        #1;
        consumer_req[1].address     = a;
        consumer_req[1].write_data  = d;
        consumer_req[1].read_valid  = 1'b1;
        consumer_req[1].write_valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!consumer_rsp[1].read_ready && !consumer_rsp[1].write_ready);
        // The whole-struct compare also requires write ready to be low
        compare_read_data("read served before write", consumer_rsp[1], expected_read(a));
        consumer_req[1].read_valid = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (!consumer_rsp[1].write_ready);
        compare_ack("read ready during later write ack", consumer_rsp[1].read_ready, 1'b0);
        consumer_req[1].write_valid = 1'b0;
        shadow[a] = d;
        do begin
            @(posedge clk);
            #1;
        end while (consumer_rsp[1].write_ready);
        compare_ack("memory holds write after read", i_mem.mem[a] === d, 1'b1);
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        for (int c = 0; c < `MC_NUM_CONSUMERS; c++) begin
            consumer_req[c] = '0;
        end
        for (int a = 0; a < 2**`MC_ADDR_BITS; a++) begin
            shadow[a] = fill_word(addr_t'(a));
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        verify_reset_state();
        read_each_consumer();
        write_then_read_back();
        load_all_consumers();
        hold_back_pressure();
        prefer_read_over_write();
        errors += i_dut.i_assert.assert_failures;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 i_dut.i_assert.assert_failures);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Ends a hung run well after the expected length of all tests
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the controller stopped answering within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_ctrl.f
+incdir+src
src/mem_ctrl_pkg.sv
src/channel_scheduler.sv
src/request_launcher.sv
src/response_router.sv
src/mem_ctrl_top.sv
testbench/tb_mem_model.sv
testbench/mem_ctrl_assert.sv
testbench/tb_mem_ctrl.sv

// File: Makefile
TOP := tb_mem_ctrl

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mem_ctrl.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
